/* rtl/tcdm_traffic_defines.svh */
/* Sizing for the TCDM traffic generator.
   The TCDM region starts at address 0 and spans TT_NUM_PORTS * TT_BANK_WORDS words.
   Port count, bank size and tile count must be powers of two. */
`ifndef TCDM_TRAFFIC_DEFINES_SVH
`define TCDM_TRAFFIC_DEFINES_SVH

// Interconnect shape
`define TT_NUM_PORTS 2
`define TT_NUM_RULES 2
`define TT_NUM_TILES 4

// Word and address sizes
`define TT_ADDR_WIDTH 32
`define TT_DATA_WIDTH 32

`define TT_MAX_OUTSTANDING 16
`define TT_BANK_WORDS 64

`endif

/* rtl/tcdm_traffic_pkg.sv */
/* Types shared by the generator, the demux and the banks.
   The ID width follows TT_MAX_OUTSTANDING, the strobe width follows TT_DATA_WIDTH. */
`include "tcdm_traffic_defines.svh"

package tcdm_traffic_pkg;

  typedef logic [`TT_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`TT_DATA_WIDTH-1:0] data_t;
  typedef logic [`TT_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [$clog2(`TT_MAX_OUTSTANDING)-1:0] id_t;
  typedef logic [$clog2(`TT_NUM_PORTS)-1:0] port_idx_t;

  // Word request from an initiator
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t strb;
    id_t   id;
  } tcdm_req_t;

  // Writes return the old word as rdata
  typedef struct packed {
    id_t   id;
    data_t rdata;
  } tcdm_resp_t;

  // Half-open range [start_addr, end_addr) mapped to one port
  typedef struct packed {
    port_idx_t idx;
    addr_t     start_addr;
    addr_t     end_addr;
  } addr_rule_t;

endpackage

/* rtl/tcdm_if.sv */
/* Request and response channels with valid/ready handshakes.
   A payload stays stable while its valid is high and ready is low. */
interface tcdm_if #(
  parameter type req_t  = logic,
  parameter type resp_t = logic
);

  // Request channel
  logic  req_valid;
  logic  req_ready;
  req_t  req;

  // Response channel
  logic  resp_valid;
  logic  resp_ready;
  resp_t resp;

  modport initiator (
    output req_valid,
    output req,
    input  req_ready,
    input  resp_valid,
    input  resp,
    output resp_ready
  );

  modport target (
    input  req_valid,
    input  req,
    output req_ready,
    output resp_valid,
    output resp,
    input  resp_ready
  );

endinterface

/* rtl/lzc.sv */
/* Finds the lowest set bit of in_i. WIDTH must be at least 2.
   cnt_o reads 0 when empty_o is high. */
module lzc #(
  parameter int unsigned WIDTH = 16
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int unsigned CntWidth = $clog2(WIDTH);

  // Scan from the top so the lowest set bit is written last
  always_comb begin
    cnt_o = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        cnt_o = CntWidth'(i);
      end
    end
  end

  assign empty_o = ~|in_i;

endmodule

/* rtl/traffic_generator.sv */
/* Random word requests with one outstanding ID per pending transaction.
   core_id_i carries the tile index in its top bits; the xorshift seed comes from it.
   Addresses are word-aligned inside the TCDM region starting at 0. */
`include "tcdm_traffic_defines.svh"

module traffic_generator (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [7:0]       core_id_i,
  input  logic             enable_i,
  tcdm_if.initiator        mem,
  output logic             full_o
);

  import tcdm_traffic_pkg::*;

  localparam int unsigned NumIds   = `TT_MAX_OUTSTANDING;
  localparam int unsigned WordBits = $clog2(`TT_NUM_PORTS * `TT_BANK_WORDS);
  localparam int unsigned TileBits = $clog2(`TT_NUM_TILES);

  logic [31:0]         rng_q, rng_d, rng_step, seed;
  logic [NumIds-1:0]   pending_q, pending_d, busy;
  logic                req_valid_q;
  tcdm_req_t           req_q, new_req;
  id_t                 next_id;
  logic                no_free_id;
  logic                can_load, issue;
  logic [TileBits-1:0] tile_id;
  logic [WordBits-1:0] word_idx;

  assign tile_id = core_id_i[7 -: TileBits];
  assign seed    = 32'h9E37_79B9 ^ {24'h0, core_id_i};

  // xorshift32 step
  always_comb begin
    rng_step = rng_q ^ (rng_q << 13);
    rng_step = rng_step ^ (rng_step >> 17);
    rng_step = rng_step ^ (rng_step << 5);
  end

  // Seeded on the first cycle out of reset, then advanced per new slot
  always_comb begin
    rng_d = rng_q;
    if (rng_q == '0) begin
      rng_d = seed;
    end else if (can_load) begin
      rng_d = rng_step;
    end
  end

  // IDs in use, counting the one still waiting for acceptance
  always_comb begin
    busy = pending_q;
    if (req_valid_q) begin
      busy[req_q.id] = 1'b1;
    end
  end

  lzc #(
    .WIDTH(NumIds)
  ) i_free_id (
    .in_i   (~busy),
    .cnt_o  (next_id),
    .empty_o(no_free_id)
  );

  // A new slot opens when nothing is held or the held request leaves
  assign can_load = !req_valid_q || mem.req_ready;
  assign issue    = enable_i && !no_free_id && (rng_q[1:0] != 2'b00);

  // Local requests stay on the core's own tile
  always_comb begin
    word_idx = rng_q[4 +: WordBits];
    if (rng_q[3]) begin
      word_idx[WordBits-1 -: TileBits] = tile_id;
    end
  end

  always_comb begin
    new_req.addr  = addr_t'({word_idx, 2'b00});
    new_req.write = rng_q[2];
    new_req.wdata = {rng_q[15:0], rng_q[31:16]};
    new_req.strb  = (rng_q[27:24] == '0) ? '1 : rng_q[27:24];
    new_req.id    = next_id;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rng_q       <= '0;
      req_valid_q <= 1'b0;
      pending_q   <= '0;
    end else begin
      rng_q     <= rng_d;
      pending_q <= pending_d;
      if (can_load) begin
        req_valid_q <= issue;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (can_load && issue) begin
      req_q <= new_req;
    end
  end

  // Set at acceptance, cleared when the response returns
  always_comb begin
    pending_d = pending_q;
    if (req_valid_q && mem.req_ready) begin
      pending_d[req_q.id] = 1'b1;
    end
    if (mem.resp_valid) begin
      pending_d[mem.resp.id] = 1'b0;
    end
  end

  assign mem.req_valid  = req_valid_q;
  assign mem.req        = req_q;
  assign mem.resp_ready = 1'b1;
  assign full_o         = &pending_q;

  a_no_reissue : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.req_valid && mem.req_ready |-> !pending_q[mem.req.id])
    else $error("request ID %0d accepted while still pending", mem.req.id);

endmodule

/* rtl/addr_demux.sv */
/* Routes each request to one port by address rule; unmatched addresses go to port 0.
   Responses merge by fixed priority, lowest port first. No added latency. */
module addr_demux #(
  parameter int unsigned NumPorts = 2,
  parameter int unsigned NumRules = 2,
  parameter type         req_t    = logic,
  parameter type         resp_t   = logic
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  tcdm_traffic_pkg::addr_rule_t [NumRules-1:0] addr_map_i,
  tcdm_if.target                                      slv,
  tcdm_if.initiator                                   mst [NumPorts]
);

  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [SelWidth-1:0] req_sel;
  logic [SelWidth-1:0] resp_sel;
  logic [NumPorts-1:0] port_req_valid;
  logic [NumPorts-1:0] port_req_ready;
  logic [NumPorts-1:0] port_resp_valid;
  logic [NumPorts-1:0] port_resp_ready;
  resp_t               port_resp [NumPorts];

  // Lowest matching rule wins
  always_comb begin
    req_sel = '0;
    for (int r = NumRules - 1; r >= 0; r--) begin
      if (slv.req.addr >= addr_map_i[r].start_addr &&
          slv.req.addr < addr_map_i[r].end_addr) begin
        req_sel = SelWidth'(addr_map_i[r].idx);
      end
    end
  end

  // Lowest valid port wins the response path
  always_comb begin
    resp_sel = '0;
    for (int p = NumPorts - 1; p >= 0; p--) begin
      if (port_resp_valid[p]) begin
        resp_sel = SelWidth'(p);
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign port_req_valid[p]  = slv.req_valid && (req_sel == p);
    assign mst[p].req_valid   = port_req_valid[p];
    assign mst[p].req         = slv.req;
    assign port_req_ready[p]  = mst[p].req_ready;

    assign port_resp_valid[p] = mst[p].resp_valid;
    assign port_resp[p]       = mst[p].resp;
    assign port_resp_ready[p] = slv.resp_ready && (resp_sel == p);
    assign mst[p].resp_ready  = port_resp_ready[p];

    // A port that loses the merge must keep offering the same response
    a_resp_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
      port_resp_valid[p] && !port_resp_ready[p] |=>
        port_resp_valid[p] && $stable(port_resp[p]))
      else $error("port %0d changed a response that was not accepted", p);
  end

  assign slv.req_ready  = port_req_ready[req_sel];
  assign slv.resp_valid = |port_resp_valid;
  assign slv.resp       = port_resp[resp_sel];

  a_onehot_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv.req_valid |-> $onehot(port_req_valid))
    else $error("request not steered to exactly one port");

endmodule

/* rtl/tcdm_bank.sv */
/* Single-cycle word memory with one response slot; writes return the old word.
   The word index is taken from the address bits just above the byte offset. */
`include "tcdm_traffic_defines.svh"

module tcdm_bank (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   stall_i,
  tcdm_if.target slv
);

  import tcdm_traffic_pkg::*;

  localparam int unsigned IdxWidth = $clog2(`TT_BANK_WORDS);
  localparam int unsigned NumBytes = $bits(strb_t);

  data_t               mem_q [`TT_BANK_WORDS];
  logic [IdxWidth-1:0] idx;
  logic                accept;
  logic                resp_valid_q;
  tcdm_resp_t          resp_q;

  assign idx = slv.req.addr[2 +: IdxWidth];

  // Accept only if the slot is free or drains this cycle
  assign slv.req_ready = !stall_i && (!resp_valid_q || slv.resp_ready);
  assign accept        = slv.req_valid && slv.req_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (slv.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= '{id: slv.req.id, rdata: mem_q[idx]};
    end
  end

  // Byte-masked write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `TT_BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (accept && slv.req.write) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (slv.req.strb[b]) begin
          mem_q[idx][8*b +: 8] <= slv.req.wdata[8*b +: 8];
        end
      end
    end
  end

  assign slv.resp_valid = resp_valid_q;
  assign slv.resp       = resp_q;

endmodule

/* rtl/tcdm_traffic_top.sv */
/* One generator, an address demux and one bank per port.
   core_id_i holds the tile index in its top bits. Observation outputs mirror the
   generator side of the demux. */
`include "tcdm_traffic_defines.svh"

module tcdm_traffic_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic [7:0]                                        core_id_i,
  input  logic                                              enable_i,
  input  tcdm_traffic_pkg::addr_rule_t [`TT_NUM_RULES-1:0]  addr_map_i,
  input  logic [`TT_NUM_PORTS-1:0]                          bank_stall_i,
  output logic                                              req_valid_o,
  output logic                                              req_ready_o,
  output tcdm_traffic_pkg::addr_t                           req_addr_o,
  output logic                                              req_write_o,
  output tcdm_traffic_pkg::data_t                           req_wdata_o,
  output tcdm_traffic_pkg::id_t                             req_id_o,
  output logic [`TT_NUM_PORTS-1:0]                          port_valid_o,
  output logic                                              resp_valid_o,
  output tcdm_traffic_pkg::id_t                             resp_id_o,
  output tcdm_traffic_pkg::data_t                           resp_rdata_o,
  output logic                                              full_o
);

  import tcdm_traffic_pkg::*;

  tcdm_if #(.req_t(tcdm_req_t), .resp_t(tcdm_resp_t)) gen_if ();
  tcdm_if #(.req_t(tcdm_req_t), .resp_t(tcdm_resp_t)) port_if [`TT_NUM_PORTS] ();

  traffic_generator i_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .core_id_i(core_id_i),
    .enable_i (enable_i),
    .mem      (gen_if),
    .full_o   (full_o)
  );

  addr_demux #(
    .NumPorts(`TT_NUM_PORTS),
    .NumRules(`TT_NUM_RULES),
    .req_t   (tcdm_req_t),
    .resp_t  (tcdm_resp_t)
  ) i_demux (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .addr_map_i(addr_map_i),
    .slv       (gen_if),
    .mst       (port_if)
  );

  for (genvar p = 0; p < `TT_NUM_PORTS; p++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .stall_i(bank_stall_i[p]),
      .slv    (port_if[p])
    );
    assign port_valid_o[p] = port_if[p].req_valid;
  end

  // Observation of the generator side
  assign req_valid_o  = gen_if.req_valid;
  assign req_ready_o  = gen_if.req_ready;
  assign req_addr_o   = gen_if.req.addr;
  assign req_write_o  = gen_if.req.write;
  assign req_wdata_o  = gen_if.req.wdata;
  assign req_id_o     = gen_if.req.id;
  assign resp_valid_o = gen_if.resp_valid;
  assign resp_id_o    = gen_if.resp.id;
  assign resp_rdata_o = gen_if.resp.rdata;

endmodule

/* testbench/tcdm_traffic_tb.sv */
/* Testbench for tcdm_traffic_top with a two-port map split at half the TCDM region.
   The byte strobe is not a top-level output and is read from the generator interface. */
`include "tcdm_traffic_defines.svh"

module tcdm_traffic_tb;

  import tcdm_traffic_pkg::*;

  localparam int NumPorts    = `TT_NUM_PORTS;
  localparam int NumIds      = `TT_MAX_OUTSTANDING;
  localparam int RegionWords = `TT_NUM_PORTS * `TT_BANK_WORDS;
  localparam int RegionBytes = RegionWords * 4;
  localparam int WordBits    = $clog2(RegionWords);
  localparam int ResetCycles = 16;
  localparam int IdleCycles  = 8;
  localparam int Phase1      = 400;
  localparam int Phase2      = 800;
  localparam int DrainLimit  = 100;
  localparam int Timeout     = ResetCycles + IdleCycles + Phase1 + Phase2 + DrainLimit + 50;

  logic                               clk_i;
  logic                               rst_ni;
  logic [7:0]                         core_id_i;
  logic                               enable_i;
  addr_rule_t [`TT_NUM_RULES-1:0]     addr_map;
  logic [NumPorts-1:0]                bank_stall_i;
  logic                               req_valid_o, req_ready_o, req_write_o;
  addr_t                              req_addr_o;
  data_t                              req_wdata_o, resp_rdata_o;
  id_t                                req_id_o, resp_id_o;
  logic [NumPorts-1:0]                port_valid_o;
  logic                               resp_valid_o, full_o;
  strb_t                              req_strb;

  // Scoreboard state
  logic [NumIds-1:0] tb_pending;
  data_t             exp_data [NumIds];
  data_t             shadow [RegionWords];
  logic              started;
  logic [31:0]       rng;
  int                errors, n_accepts, n_resps, n_writes, n_holds, drain_cycles;

  tcdm_traffic_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_id_i   (core_id_i),
    .enable_i    (enable_i),
    .addr_map_i  (addr_map),
    .bank_stall_i(bank_stall_i),
    .req_valid_o (req_valid_o),
    .req_ready_o (req_ready_o),
    .req_addr_o  (req_addr_o),
    .req_write_o (req_write_o),
    .req_wdata_o (req_wdata_o),
    .req_id_o    (req_id_o),
    .port_valid_o(port_valid_o),
    .resp_valid_o(resp_valid_o),
    .resp_id_o   (resp_id_o),
    .resp_rdata_o(resp_rdata_o),
    .full_o      (full_o)
  );

  assign req_strb = dut0.gen_if.req.strb;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t wdata, strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) result[8*b +: 8] = wdata[8*b +: 8];
    end
    return result;
  endfunction

  // First matching rule picks the port, no match falls back to port 0
  function automatic logic [NumPorts-1:0] port_for_addr(addr_t a);
    logic [NumPorts-1:0] sel;
    logic                found;
    sel   = '0;
    found = 1'b0;
    for (int r = 0; r < `TT_NUM_RULES; r++) begin
      if (!found && a >= addr_map[r].start_addr && a < addr_map[r].end_addr) begin
        sel[addr_map[r].idx] = 1'b1;
        found = 1'b1;
      end
    end
    if (!found) sel[0] = 1'b1;
    return sel;
  endfunction

  task automatic record_failure(string msg);
    errors++;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  task automatic report_missed(string msg);
    errors++;
    $display("Stimulus gap: %s", msg);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Shadow memory and per-ID expectations, updated in acceptance order
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tb_pending <= '0;
      started    <= 1'b0;
    end else begin
      if (enable_i) started <= 1'b1;
      if (req_valid_o && !req_ready_o) n_holds++;
      if (req_valid_o && req_ready_o) begin
        n_accepts++;
        tb_pending[req_id_o] <= 1'b1;
        exp_data[req_id_o]   <= shadow[req_addr_o[2 +: WordBits]];
        if (req_write_o) begin
          n_writes++;
          shadow[req_addr_o[2 +: WordBits]] <=
            merge_bytes(shadow[req_addr_o[2 +: WordBits]], req_wdata_o, req_strb);
        end
      end
      if (resp_valid_o) begin
        n_resps++;
        tb_pending[resp_id_o] <= 1'b0;
      end
    end
  end

  a_quiet_before_enable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started |-> !req_valid_o && !resp_valid_o && !full_o && port_valid_o == '0)
    else record_failure("output active before enable");

  a_free_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o && req_ready_o |-> !tb_pending[req_id_o])
    else record_failure($sformatf("request ID %0d accepted while pending", req_id_o));

  a_known_resp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> tb_pending[resp_id_o])
    else record_failure($sformatf("response ID %0d was not pending", resp_id_o));

  a_addr_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o |-> req_addr_o[1:0] == 2'b00 && req_addr_o < RegionBytes)
    else record_failure($sformatf("bad request address 0x%08h", req_addr_o));

  a_port_route : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o |-> port_valid_o == port_for_addr(req_addr_o))
    else record_failure($sformatf("address 0x%08h routed to ports %b", req_addr_o,
                                  port_valid_o));

  a_read_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> resp_rdata_o == exp_data[resp_id_o])
    else record_failure($sformatf("ID %0d data 0x%08h, expected 0x%08h", resp_id_o,
                                  resp_rdata_o, exp_data[resp_id_o]));

  a_payload_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o && !req_ready_o |=> req_valid_o && $stable(req_addr_o) &&
      $stable(req_write_o) && $stable(req_wdata_o) && $stable(req_id_o) &&
      $stable(req_strb))
    else record_failure("request payload changed while waiting for ready");

  // Only one response in flight means no collision
  a_resp_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o && req_ready_o |=> resp_valid_o &&
      (resp_id_o == $past(req_id_o) || $countones(tb_pending) > 1))
    else record_failure("response did not follow acceptance by one cycle");

  // Full exactly when every ID is waiting for its response
  a_full_match : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o == (tb_pending == '1))
    else record_failure($sformatf("full flag %b with pending IDs %b", full_o, tb_pending));

  a_full_blocks : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !(req_valid_o && req_ready_o))
    else record_failure("request accepted while full");

  initial begin
    #(Timeout * 10);
    $display("Watchdog timeout: run did not finish within %0d cycles", Timeout);
    $display("Regression failed");
    $finish;
  end

  initial begin
    errors       = 0;
    n_accepts    = 0;
    n_resps      = 0;
    n_writes     = 0;
    n_holds      = 0;
    drain_cycles = 0;
    rng          = 32'd2928;
    for (int w = 0; w < RegionWords; w++) shadow[w] = '0;
    rst_ni       <= 1'b0;
    enable_i     <= 1'b0;
    core_id_i    <= 8'h40;
    bank_stall_i <= '0;
    // Low half to port 0, high half to port 1
    addr_map[0] <= '{idx: 1'b0, start_addr: addr_t'(0), end_addr: addr_t'(RegionBytes / 2)};
    addr_map[1] <= '{idx: 1'b1, start_addr: addr_t'(RegionBytes / 2),
                     end_addr: addr_t'(RegionBytes)};
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (IdleCycles) @(posedge clk_i);

    // Free running
    enable_i <= 1'b1;
    repeat (Phase1) @(posedge clk_i);

    // Random stalls, about one cycle in four per port
    repeat (Phase2) begin
      @(posedge clk_i);
      rng = xorshift32(rng);
      bank_stall_i <= rng[NumPorts-1:0] & rng[8 +: NumPorts];
    end

    // Drain
    @(posedge clk_i);
    bank_stall_i <= '0;
    enable_i     <= 1'b0;
    @(negedge clk_i);
    while ((req_valid_o || tb_pending != '0) && drain_cycles < DrainLimit) begin
      @(negedge clk_i);
      drain_cycles++;
    end
    assert (tb_pending == '0 && !req_valid_o)
      else record_failure($sformatf("IDs still pending after drain: %b", tb_pending));
    assert (n_resps == n_accepts)
      else record_failure($sformatf("%0d requests but %0d responses", n_accepts, n_resps));

    if (n_holds == 0) report_missed("no request was ever held by a stall");
    if (n_writes == 0) report_missed("no write request was accepted");

    $display("Errors: %0d, accepted: %0d, responses: %0d, writes: %0d, stall holds: %0d",
             errors, n_accepts, n_resps, n_writes, n_holds);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tcdm_traffic.f */
+incdir+rtl
rtl/tcdm_traffic_pkg.sv
rtl/tcdm_if.sv
rtl/lzc.sv
rtl/traffic_generator.sv
rtl/addr_demux.sv
rtl/tcdm_bank.sv
rtl/tcdm_traffic_top.sv
testbench/tcdm_traffic_tb.sv
